// File: design/core_control.sv
// Core sequencing FSM with the PC and instruction registers
// selects the writeback value and forms the retire record
`timescale 1ns/1ps

module core_control import rv_core_pkg::*; #(
    parameter xlen_t RESET_PC = DEFAULT_RESET_PC
) (
    input  logic        clk,
    input  logic        reset,
    input  xlen_t       imem_rdata,
    input  decode_t     dec,
    input  xlen_t       next_pc,
    input  xlen_t       exec_value,
    input  xlen_t       load_value,
    output xlen_t       inst,
    output xlen_t       pc,
    output logic [29:0] imem_addr,
    output logic        imem_req,
    output logic        mem_phase,
    output logic        rf_we,
    output xlen_t       rf_wdata,
    output logic        retire_valid,
    output retire_t     retire
);
    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        active;    // low for the first cycle out of reset
    logic        is_load;

    assign is_load = (dec.opcode == LOAD);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= FETCH;
            active <= 1'b0;
        end else begin
            state  <= state_next;
            active <= 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            FETCH:    state_next = active ? DECODE : FETCH;
            DECODE:   state_next = EXECUTE;
            EXECUTE:  state_next = is_load ? MEM_WAIT : FETCH;
            MEM_WAIT: state_next = FETCH;
            default:  state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (retire_valid) begin
            pc <= next_pc;
        end
    end

    // imem word arrives during DECODE
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            inst <= '0;
        end else if (state == DECODE) begin
            inst <= imem_rdata;
        end
    end

    assign imem_req  = (state == FETCH) && active;
    assign imem_addr = pc[31:2];
    assign mem_phase = (state == EXECUTE);

    // loads retire a cycle later once dmem data is back
    assign retire_valid = (state == EXECUTE && !is_load) || (state == MEM_WAIT);
    assign rf_wdata     = (state == MEM_WAIT) ? load_value : exec_value;
    assign rf_we        = retire_valid && dec.we;

    assign retire = '{
        pc:      pc,
        rd:      dec.rd,
        wdata:   rf_wdata,
        we:      dec.we,
        illegal: dec.illegal
    };

endmodule

// File: design/execute_unit.sv
// Execute stage: ALU, branch compare, next PC and non-load writeback value
`timescale 1ns/1ps

module execute_unit import rv_core_pkg::*; (
    input  decode_t dec,
    input  xlen_t   pc,
    input  xlen_t   rs1_data,
    input  xlen_t   rs2_data,
    output xlen_t   exec_value,
    output xlen_t   next_pc,
    output xlen_t   mem_addr
);
    xlen_t op_a;
    xlen_t op_b;
    xlen_t sum;
    xlen_t alu_result;
    xlen_t pc_plus4;
    logic  taken;

    always_comb begin
        case (dec.opcode)
            AUIPC, JAL, BRANCH: op_a = pc;
            LUI:                op_a = '0;
            default:            op_a = rs1_data;
        endcase
        op_b = (dec.fmt == FMT_R) ? rs2_data : dec.imm;
    end

    assign sum      = op_a + op_b;
    assign mem_addr = sum;           // load/store effective address
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (dec.alu_op)
            ADD:     alu_result = sum;
            SUB:     alu_result = op_a - op_b;
            SLL:     alu_result = op_a << op_b[4:0];
            SLT:     alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_result = {31'b0, op_a < op_b};
            XOR:     alu_result = op_a ^ op_b;
            SRL:     alu_result = op_a >> op_b[4:0];
            SRA:     alu_result = xlen_t'($signed(op_a) >>> op_b[4:0]);
            OR:      alu_result = op_a | op_b;
            AND:     alu_result = op_a & op_b;
            default: alu_result = sum;
        endcase
    end

    // branches compare the registers, not the ALU operands
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if ((dec.opcode == BRANCH && taken) || dec.opcode == JAL) begin
            next_pc = sum;
        end else if (dec.opcode == JALR) begin
            next_pc = {sum[31:1], 1'b0};
        end else begin
            next_pc = pc_plus4;
        end
    end

    // link value for jumps
    assign exec_value = (dec.opcode == JAL || dec.opcode == JALR) ? pc_plus4 : alu_result;

endmodule

// File: design/inst_decoder.sv
// RV32I instruction decoder: fields, format, immediate and ALU operation
`timescale 1ns/1ps

module inst_decoder import rv_core_pkg::*; (
    input  xlen_t   inst,
    output decode_t dec
);
    opcode_t   opcode;
    inst_fmt_t fmt;
    alu_op_t   alu_op;
    xlen_t     imm;
    logic      alt;       // inst[30], selects SUB / SRA

    assign opcode = opcode_t'(inst[6:0]);
    assign alt    = inst[30];

    always_comb begin
        case (opcode)
            OP:                  fmt = FMT_R;
            OP_IMM, LOAD, JALR:  fmt = FMT_I;
            STORE:               fmt = FMT_S;
            BRANCH:              fmt = FMT_B;
            LUI, AUIPC:          fmt = FMT_U;
            JAL:                 fmt = FMT_J;
            default:             fmt = FMT_N;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I:   imm = {{20{inst[31]}}, inst[31:20]};
            FMT_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            FMT_B:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            FMT_U:   imm = {inst[31:12], 12'b0};
            FMT_J:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // loads, stores, branches and jumps all add
    always_comb begin
        alu_op = ADD;
        if (opcode == OP || opcode == OP_IMM) begin
            case (inst[14:12])
                3'b000:  alu_op = (fmt == FMT_R && alt) ? SUB : ADD;
                3'b001:  alu_op = SLL;
                3'b010:  alu_op = SLT;
                3'b011:  alu_op = SLTU;
                3'b100:  alu_op = XOR;
                3'b101:  alu_op = alt ? SRA : SRL;   // also for SRAI
                3'b110:  alu_op = OR;
                default: alu_op = AND;
            endcase
        end
    end

    always_comb begin
        dec.opcode  = opcode;
        dec.funct3  = inst[14:12];
        dec.rd      = inst[11:7];
        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.imm     = imm;
        dec.fmt     = fmt;
        dec.alu_op  = alu_op;
        dec.illegal = (fmt == FMT_N);
        dec.we      = (inst[11:7] != '0)
                      && (fmt != FMT_S) && (fmt != FMT_B) && (fmt != FMT_N);
    end

endmodule

// File: design/load_store_unit.sv
// Load/store unit: dmem strobes, store lane shift and byte mask,
// load byte/half extraction with sign or zero extension
`timescale 1ns/1ps

module load_store_unit import rv_core_pkg::*; (
    input  decode_t   dec,
    input  logic      mem_phase,
    input  xlen_t     mem_addr,
    input  xlen_t     rs2_data,
    input  xlen_t     dmem_rdata,
    output dmem_req_t dmem_req,
    output xlen_t     load_value
);
    logic [4:0] lane_shift;    // byte offset in bits
    byte_mask_t mask;
    xlen_t      rdata_shifted;

    assign lane_shift = {mem_addr[1:0], 3'b000};

    always_comb begin
        case (dec.funct3[1:0])
            2'b00:   mask = byte_mask_t'(4'b0001 << mem_addr[1:0]);   // SB
            2'b01:   mask = byte_mask_t'(4'b0011 << mem_addr[1:0]);   // SH
            2'b10:   mask = 4'b1111;                                  // SW
            default: mask = 4'b0000;
        endcase
    end

    assign dmem_req.addr  = mem_addr;
    assign dmem_req.wdata = rs2_data << lane_shift;
    assign dmem_req.mask  = mask;
    assign dmem_req.re    = mem_phase && (dec.opcode == LOAD);
    assign dmem_req.we    = mem_phase && (dec.opcode == STORE);

    // move the addressed byte or half down to bit 0
    assign rdata_shifted = dmem_rdata >> lane_shift;

    always_comb begin
        case (dec.funct3)
            3'b000:  load_value = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};     // LB
            3'b001:  load_value = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};   // LH
            3'b010:  load_value = dmem_rdata;                                       // LW
            3'b100:  load_value = {24'b0, rdata_shifted[7:0]};                      // LBU
            3'b101:  load_value = {16'b0, rdata_shifted[15:0]};                     // LHU
            default: load_value = '0;
        endcase
    end

endmodule

// File: design/reg_file.sv
// 32 x 32 general register file, two combinational read ports, x0 reads zero
`timescale 1ns/1ps

module reg_file import rv_core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1_addr,
    input  reg_idx_t rs2_addr,
    input  reg_idx_t rd_addr,
    input  logic     we,
    input  xlen_t    wdata,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data
);
    xlen_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            regs[rd_addr] <= wdata;
        end
    end

    // entry 0 stays at its reset value
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// File: design/rv_core.sv
// RV32I multi-cycle core top level
// one instruction in flight, fixed one-cycle memories on the ports
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; #(
    parameter xlen_t RESET_PC = DEFAULT_RESET_PC
) (
    input  logic        clk,
    input  logic        reset,
    output logic [29:0] imem_addr,
    output logic        imem_req,
    input  xlen_t       imem_rdata,
    output dmem_req_t   dmem_req,
    input  xlen_t       dmem_rdata,
    output logic        retire_valid,
    output retire_t     retire
);
    xlen_t   inst;
    xlen_t   pc;
    decode_t dec;
    xlen_t   rs1_data;
    xlen_t   rs2_data;
    xlen_t   exec_value;
    xlen_t   next_pc;
    xlen_t   mem_addr;
    xlen_t   load_value;
    xlen_t   rf_wdata;
    logic    rf_we;
    logic    mem_phase;

    core_control #(
        .RESET_PC(RESET_PC)
    ) u_control (
        .clk         (clk),
        .reset       (reset),
        .imem_rdata  (imem_rdata),
        .dec         (dec),
        .next_pc     (next_pc),
        .exec_value  (exec_value),
        .load_value  (load_value),
        .inst        (inst),
        .pc          (pc),
        .imem_addr   (imem_addr),
        .imem_req    (imem_req),
        .mem_phase   (mem_phase),
        .rf_we       (rf_we),
        .rf_wdata    (rf_wdata),
        .retire_valid(retire_valid),
        .retire      (retire)
    );

    inst_decoder u_decoder (
        .inst(inst),
        .dec (dec)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs1_addr(dec.rs1),
        .rs2_addr(dec.rs2),
        .rd_addr (dec.rd),
        .we      (rf_we),
        .wdata   (rf_wdata),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    execute_unit u_execute (
        .dec       (dec),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .exec_value(exec_value),
        .next_pc   (next_pc),
        .mem_addr  (mem_addr)
    );

    load_store_unit u_lsu (
        .dec       (dec),
        .mem_phase (mem_phase),
        .mem_addr  (mem_addr),
        .rs2_data  (rs2_data),
        .dmem_rdata(dmem_rdata),
        .dmem_req  (dmem_req),
        .load_value(load_value)
    );

endmodule

// File: design/rv_core_pkg.sv
// RV32I multi-cycle core: shared widths, opcode and state encodings,
// and the decode, data memory and retire records
package rv_core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_mask_t;

    localparam xlen_t DEFAULT_RESET_PC = 32'h0000_0000;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J,
        FMT_N   // no valid format
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_t;

    typedef enum logic [1:0] {
        FETCH, DECODE, EXECUTE, MEM_WAIT
    } ctrl_state_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] funct3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        xlen_t      imm;
        inst_fmt_t  fmt;
        alu_op_t    alu_op;
        logic       we;        // low for rd == x0
        logic       illegal;
    } decode_t;

    typedef struct packed {
        xlen_t      addr;      // byte address
        xlen_t      wdata;     // already lane shifted
        byte_mask_t mask;
        logic       re;
        logic       we;
    } dmem_req_t;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        xlen_t    wdata;
        logic     we;
        logic     illegal;
    } retire_t;

endpackage

// File: list.f
design/rv_core_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/execute_unit.sv
design/load_store_unit.sv
design/core_control.sv
design/rv_core.sv
testbench/rv_core_sva.sv
testbench/tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_core \
    -f list.f \
    -o sim_tb_rv_core

./obj_dir/sim_tb_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
exit 1

// File: testbench/rv_core_sva.sv
// Protocol assertions on the fetch, memory phase and retire strobes
`timescale 1ns/1ps

module rv_core_sva (
    input logic clk,
    input logic reset,
    input logic imem_req,
    input logic mem_phase,
    input logic retire_valid
);

    a_fetch_one_cycle: assert property (
        @(posedge clk) disable iff (reset) imem_req |=> !imem_req
    ) else $error("imem_req held longer than one cycle");

    a_retire_spaced: assert property (
        @(posedge clk) disable iff (reset) retire_valid |=> !retire_valid
    ) else $error("retire_valid in two consecutive cycles");

    // dmem strobes rise only in the memory phase two cycles after the fetch
    a_mem_phase_after_fetch: assert property (
        @(posedge clk) disable iff (reset)
            imem_req |-> !mem_phase ##1 !mem_phase ##1 mem_phase
    ) else $error("memory phase not two cycles after the instruction fetch");

endmodule

bind core_control rv_core_sva u_sva (
    .clk         (clk),
    .reset       (reset),
    .imem_req    (imem_req),
    .mem_phase   (mem_phase),
    .retire_valid(retire_valid)
);

// File: testbench/rv_core_testdata.txt
// header: program words, data words, retires, stores (hex counts)
// then program, data, retires (pc rd value we illegal), stores (addr data mask)
0000002C 00000003 00000025 00000003
00500093 FFD00113 002081B3 40208233 001092B3 00112333 001133B3 0020C433
001154B3 40115533 0020E5B3 0020F633 123456B7 00001717 00708013 001007B3
00108463 00100813 00109463 00114463 00100813 00115463 0020E463 00100813
0020F463 008008EF 00100813 07800993 00498967 00100813 00100813 00000A03
00004A83 00201B03 00205B83 00402C03 00100C83 001004A3 00201523 00D02623
00802D03 00C02D83 FFFFFFFF 0000006F
80F07F81 12345678 000000AA
00000000 01 00000005 1 0   00000004 02 FFFFFFFD 1 0   00000008 03 00000002 1 0
0000000C 04 00000008 1 0   00000010 05 000000A0 1 0   00000014 06 00000001 1 0
00000018 07 00000000 1 0   0000001C 08 FFFFFFF8 1 0   00000020 09 07FFFFFF 1 0
00000024 0A FFFFFFFF 1 0   00000028 0B FFFFFFFD 1 0   0000002C 0C 00000005 1 0
00000030 0D 12345000 1 0   00000034 0E 00001034 1 0   00000038 00 00000000 0 0
0000003C 0F 00000005 1 0   00000040 00 00000000 0 0   00000048 00 00000000 0 0
0000004C 00 00000000 0 0   00000054 00 00000000 0 0   00000058 00 00000000 0 0
00000060 00 00000000 0 0   00000064 11 00000068 1 0   0000006C 13 00000078 1 0
00000070 12 00000074 1 0   0000007C 14 FFFFFF81 1 0   00000080 15 00000081 1 0
00000084 16 FFFF80F0 1 0   00000088 17 000080F0 1 0   0000008C 18 12345678 1 0
00000090 19 0000007F 1 0   00000094 00 00000000 0 0   00000098 00 00000000 0 0
0000009C 00 00000000 0 0   000000A0 1A FFFD05AA 1 0   000000A4 1B 12345000 1 0
000000A8 00 00000000 0 1
00000009 00000500 2
0000000A FFFD0000 C
0000000C 12345000 F

// File: testbench/tb_rv_core.sv
// Testbench for the RV32I multi-cycle core
// serves instruction and data memory and checks retires and stores
`timescale 1ns/1ps

module tb_rv_core import rv_core_pkg::*;;
    localparam int    TD_WORDS = 512;
    localparam int    MARGIN   = 20;    // extra cycles past the worst case
    localparam xlen_t RESET_PC = 32'h0;

    logic        clk;
    logic        reset;
    logic [29:0] imem_addr;
    logic        imem_req;
    xlen_t       imem_rdata;
    dmem_req_t   dmem_req;
    xlen_t       dmem_rdata;
    logic        retire_valid;
    retire_t     retire;

    xlen_t tdata [TD_WORDS];
    xlen_t imem  [256];
    xlen_t dmem  [64];
    int    n_prog, n_data, n_ret, n_store;
    int    ret_base, st_base;
    int    ret_idx, st_idx;
    int    value_errors, other_errors;
    logic  fetch_seen;

    rv_core #(
        .RESET_PC(RESET_PC)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .imem_addr   (imem_addr),
        .imem_req    (imem_req),
        .imem_rdata  (imem_rdata),
        .dmem_req    (dmem_req),
        .dmem_rdata  (dmem_rdata),
        .retire_valid(retire_valid),
        .retire      (retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare_value(input string name, input xlen_t exp, input xlen_t act);
        assert (exp === act) else begin
            value_errors++;
            $display("[FAIL] %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    // one-cycle memories without back-pressure
    always @(posedge clk) begin
        if (imem_req) imem_rdata <= imem[imem_addr[7:0]];
        if (dmem_req.re) dmem_rdata <= dmem[dmem_req.addr[7:2]];
        if (dmem_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_req.mask[b]) begin
                    dmem[dmem_req.addr[7:2]][b*8 +: 8] = dmem_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            assert (!imem_req && !dmem_req.re && !dmem_req.we && !retire_valid) else begin
                other_errors++;
                $display("strobe or retire seen while reset is high");
            end
        end else begin
            if (imem_req && !fetch_seen) begin
                fetch_seen <= 1'b1;
                compare_value("first fetch address", RESET_PC, {imem_addr, 2'b00});
            end
            if (retire_valid && ret_idx < n_ret) begin
                compare_value($sformatf("retire %0d pc", ret_idx),
                              tdata[ret_base + ret_idx*5], retire.pc);
                compare_value($sformatf("retire %0d we", ret_idx),
                              tdata[ret_base + ret_idx*5 + 3], 32'(retire.we));
                compare_value($sformatf("retire %0d illegal", ret_idx),
                              tdata[ret_base + ret_idx*5 + 4], 32'(retire.illegal));
                if (tdata[ret_base + ret_idx*5 + 3] != 0) begin   // value only when written
                    compare_value($sformatf("retire %0d rd", ret_idx),
                                  tdata[ret_base + ret_idx*5 + 1], 32'(retire.rd));
                    compare_value($sformatf("retire %0d value", ret_idx),
                                  tdata[ret_base + ret_idx*5 + 2], retire.wdata);
                end
                ret_idx <= ret_idx + 1;
            end
            if (dmem_req.we) begin
                assert (st_idx < n_store) else begin
                    other_errors++;
                    $display("more stores than expected");
                end
                if (st_idx < n_store) begin
                    compare_value($sformatf("store %0d addr", st_idx),
                                  tdata[st_base + st_idx*3], dmem_req.addr);
                    compare_value($sformatf("store %0d data", st_idx),
                                  tdata[st_base + st_idx*3 + 1], dmem_req.wdata);
                    compare_value($sformatf("store %0d mask", st_idx),
                                  tdata[st_base + st_idx*3 + 2], 32'(dmem_req.mask));
                end
                st_idx <= st_idx + 1;
            end
        end
    end

    initial begin
        reset      <= 1'b1;
        imem_rdata <= '0;
        dmem_rdata <= '0;
        ret_idx    <= 0;
        st_idx     <= 0;
        fetch_seen <= 1'b0;
        value_errors = 0;
        other_errors = 0;
        foreach (tdata[i]) tdata[i] = '0;
        foreach (imem[i]) imem[i] = '0;
        foreach (dmem[i]) dmem[i] = '0;
        $readmemh("testbench/rv_core_testdata.txt", tdata);
        n_prog   = tdata[0];
        n_data   = tdata[1];
        n_ret    = tdata[2];
        n_store  = tdata[3];
        ret_base = 4 + n_prog + n_data;
        st_base  = ret_base + n_ret*5;
        for (int i = 0; i < n_prog; i++) imem[i] = tdata[4 + i];
        for (int i = 0; i < n_data; i++) dmem[i] = tdata[4 + n_prog + i];

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        wait (ret_idx == n_ret);
        @(posedge clk);
        assert (st_idx == n_store) else begin
            other_errors++;
            $display("store count %0d does not match %0d", st_idx, n_store);
        end
        $display("errors: value %0d, other %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // worst case 4 cycles per retire
    initial begin
        #1;
        #((n_ret*4 + MARGIN + 5) * 100);
        $display("timeout after %0d of %0d retires", ret_idx, n_ret);
        $display("Testbench failed");
        $finish;
    end

endmodule
